//--- compile.f
rx_pkg.sv
rx_link_config.sv
rx_deserializer.sv
rx_lock_monitor.sv
serial_rx_top.sv
serial_rx_checker.sv
serial_rx_tb.sv

//--- Bender.yml
package:
  name: serial_rx

sources:
  - rx_pkg.sv
  - rx_link_config.sv
  - rx_deserializer.sv
  - rx_lock_monitor.sv
  - serial_rx_top.sv
  - target: test
    files:
      - serial_rx_checker.sv
      - serial_rx_tb.sv

//--- serial_rx_tb.sv
// Testbench for the serial receive front end
// Sends random bits, aligned training words, bitslip requests and bad words;
// the bound checker judges the responses

`timescale 1ns/100ps
`default_nettype none

module serial_rx_tb
  import rx_pkg::*;
();

  localparam int clk_period      = 4;
  localparam int random_words    = 8;
  localparam int train_words     = 6;   // More than lock_count
  localparam int bad_words       = 20;  // More than search_limit
  localparam int watchdog_cycles = 400; // Stimulus takes about 200 cycles

  logic  clk_in_clkbuf;
  logic  reset_ibuf;
  logic  i1;
  logic  i2;
  logic  bitslip_adj;
  word_t data_out;
  logic  data_valid;
  logic  dpa_loc;
  logic  dpa_err;
  int    total_errors;

  serial_rx_top dut0 (
    .clk_in_clkbuf (clk_in_clkbuf),
    .reset_ibuf    (reset_ibuf),
    .i1            (i1),
    .i2            (i2),
    .bitslip_adj   (bitslip_adj),
    .data_out      (data_out),
    .data_valid    (data_valid),
    .dpa_loc       (dpa_loc),
    .dpa_err       (dpa_err)
  );

  initial begin
    clk_in_clkbuf = 1'b0;
    forever #(clk_period / 2) clk_in_clkbuf = ~clk_in_clkbuf;
  end

  // One serial bit per clock, sampled by the DUT on the following edge
  task automatic drive_bit(input logic a, input logic b, input logic slip);
    @(posedge clk_in_clkbuf);
    i1          <= a;
    i2          <= b;
    bitslip_adj <= slip;
  endtask

  // MSB goes out first, i2 held high so i1 carries the bit
  task automatic send_word(input word_t w, input logic slip_last);
    for (int i = word_width - 1; i >= 0; i--) begin
      drive_bit(w[i], 1'b1, slip_last && (i == 0));
    end
  endtask

  task automatic send_random_bits(input int n);
    logic [1:0] pins;
    for (int i = 0; i < n; i++) begin
      pins = 2'($urandom());
      drive_bit(pins[1], pins[0], 1'b0);
    end
  endtask

  task automatic send_training(input int n);
    for (int i = 0; i < n; i++) begin
      send_word(train_word, 1'b0);
    end
  endtask

  task automatic send_bad_words(input int n);
    word_t w;
    for (int i = 0; i < n; i++) begin
      w = word_t'($urandom());
      if (w == train_word) begin
        w = ~w;
      end
      send_word(w, 1'b0);
    end
  endtask

  // Request rises with the last bit of a training word, so the slip cycle
  // lands on a filler bit and the next word starts on the new boundary
  task automatic slip_boundary();
    send_word(train_word, 1'b1);
    drive_bit(1'b0, 1'b1, 1'b1); // Held level, no second slip
  endtask

  initial begin
    reset_ibuf  = 1'b1;
    i1          = 1'b0;
    i2          = 1'b0;
    bitslip_adj = 1'b0;
    void'($urandom(32'h5f78_cb26));
    #1 reset_ibuf = 1'b0;
    repeat (2) @(posedge clk_in_clkbuf);
    reset_ibuf <= 1'b1;

    send_random_bits(random_words * word_width);
    send_training(train_words);  // Reaches lock
    slip_boundary();             // Drops lock
    send_training(train_words);
    slip_boundary();
    send_bad_words(bad_words);   // Raises dpa_err
    send_training(train_words);  // Lock clears the error
    for (int i = 0; i < 8; i++) begin
      drive_bit(1'b0, 1'b0, 1'b0); // Lets pending checks finish
    end

    total_errors = dut0.chk0.value_fails + dut0.chk0.event_fails;
    $display("Errors: %0d wrong values, %0d missing events, %0d total",
             dut0.chk0.value_fails, dut0.chk0.event_fails, total_errors);
    if (total_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("Timeout: the run did not finish within %0d clock periods", watchdog_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule : serial_rx_tb

`default_nettype wire

//--- serial_rx_checker.sv
// Assertion checker for the serial receive front end
// Keeps its own pin history at the top-level ports and checks word contents,
// word spacing, lock and error behavior

`timescale 1ns/100ps
`default_nettype none

module serial_rx_checker
  import rx_pkg::*;
(
  input logic  clk_in_clkbuf,
  input logic  reset_ibuf,
  input logic  i1,
  input logic  i2,
  input logic  bitslip_adj,
  input word_t data_out,
  input logic  data_valid,
  input logic  dpa_loc,
  input logic  dpa_err
);

  int value_fails = 0; // Wrong values seen
  int event_fails = 0; // Expected events that never came

  word_t      bits_hist;  // Last four pin products, newest in the LSB
  logic       bitslip_q1; // bitslip_adj one cycle back
  logic       bitslip_q2; // and two cycles back
  logic       slip_now;
  logic [3:0] gap_cnt;    // Cycles since the last data_valid
  logic       slip_seen;  // Slip cycle inside the current gap
  logic       seen_valid;
  logic [3:0] exp_gap;
  match_cnt_t train_run;  // Consecutive training words since the last slip
  match_cnt_t miss_run;   // Consecutive other words since the last slip
  logic       outputs_idle;
  logic       lock_event;
  logic       err_event;

  // The DUT slips one cycle after it sees the rising edge
  assign slip_now     = bitslip_q1 & ~bitslip_q2;
  assign exp_gap      = slip_seen ? 4'd5 : 4'd4;
  assign outputs_idle = (data_out == '0) && !data_valid && !dpa_loc && !dpa_err;

  // Word that completes a training run
  assign lock_event = data_valid && !slip_now && (data_out == train_word) &&
                      (train_run == lock_count - match_cnt_t'(1));

  // Word that completes a run of misses while searching
  assign err_event = data_valid && !slip_now && (data_out != train_word) &&
                     (miss_run == search_limit - match_cnt_t'(1)) && !dpa_loc;

  always_ff @(posedge clk_in_clkbuf or negedge reset_ibuf) begin
    if (!reset_ibuf) begin
      bits_hist  <= '0;
      bitslip_q1 <= 1'b0;
      bitslip_q2 <= 1'b0;
      gap_cnt    <= '0;
      slip_seen  <= 1'b0;
      seen_valid <= 1'b0;
      train_run  <= '0;
      miss_run   <= '0;
    end else begin
      bits_hist  <= {bits_hist[word_width-2:0], i1 & i2};
      bitslip_q1 <= bitslip_adj;
      bitslip_q2 <= bitslip_q1;
      if (data_valid) begin
        seen_valid <= 1'b1;
        gap_cnt    <= 4'd1;
        slip_seen  <= slip_now;
      end else begin
        if (gap_cnt != 4'hf) begin
          gap_cnt <= gap_cnt + 4'd1; // Saturates
        end
        slip_seen <= slip_seen | slip_now;
      end
      if (slip_now) begin
        train_run <= '0;
        miss_run  <= '0;
      end else if (data_valid) begin
        if (data_out == train_word) begin
          train_run <= (train_run == lock_count) ? train_run : train_run + match_cnt_t'(1);
          miss_run  <= '0;
        end else begin
          train_run <= '0;
          miss_run  <= (miss_run == search_limit) ? miss_run : miss_run + match_cnt_t'(1);
        end
      end
    end
  end

  a_reset_idle: assert property (@(posedge clk_in_clkbuf)
    !reset_ibuf |-> outputs_idle)
    else begin
      value_fails++;
      $error("[FAIL] %0t outputs not idle during reset", $time);
    end

  a_release_idle: assert property (@(posedge clk_in_clkbuf)
    $rose(reset_ibuf) |-> outputs_idle ##1 outputs_idle)
    else begin
      value_fails++;
      $error("[FAIL] %0t outputs not idle right after reset release", $time);
    end

  a_word_bits: assert property (@(posedge clk_in_clkbuf) disable iff (!reset_ibuf)
    data_valid |-> data_out == bits_hist)
    else begin
      value_fails++;
      $error("[FAIL] %0t data_out %h, last four bits %h", $time,
             $sampled(data_out), $sampled(bits_hist));
    end

  a_gap_len: assert property (@(posedge clk_in_clkbuf) disable iff (!reset_ibuf)
    data_valid && seen_valid |-> gap_cnt == exp_gap)
    else begin
      value_fails++;
      $error("[FAIL] %0t data_valid gap %0d, expected %0d", $time,
             $sampled(gap_cnt), $sampled(exp_gap));
    end

  a_gap_missing: assert property (@(posedge clk_in_clkbuf) disable iff (!reset_ibuf)
    seen_valid && !data_valid |-> gap_cnt < exp_gap)
    else begin
      event_fails++;
      $error("data_valid pulse missing after a full word");
    end

  a_lock_rise: assert property (@(posedge clk_in_clkbuf) disable iff (!reset_ibuf)
    lock_event |-> ##[1:2] dpa_loc)
    else begin
      event_fails++;
      $error("dpa_loc did not rise after a run of training words");
    end

  a_lock_cause: assert property (@(posedge clk_in_clkbuf) disable iff (!reset_ibuf)
    $rose(dpa_loc) |-> $past(lock_event, 2))
    else begin
      value_fails++;
      $error("[FAIL] %0t dpa_loc rose without a run of training words", $time);
    end

  a_slip_unlock: assert property (@(posedge clk_in_clkbuf) disable iff (!reset_ibuf)
    $rose(bitslip_adj) && dpa_loc |-> ##[1:3] !dpa_loc)
    else begin
      event_fails++;
      $error("dpa_loc did not fall after a bitslip request");
    end

  a_err_rise: assert property (@(posedge clk_in_clkbuf) disable iff (!reset_ibuf)
    err_event |-> ##[1:2] dpa_err)
    else begin
      event_fails++;
      $error("dpa_err did not rise after a long run of bad words");
    end

  a_err_sticky: assert property (@(posedge clk_in_clkbuf) disable iff (!reset_ibuf)
    $fell(dpa_err) |-> $rose(dpa_loc))
    else begin
      value_fails++;
      $error("[FAIL] %0t dpa_err fell without lock", $time);
    end

endmodule : serial_rx_checker

bind serial_rx_top serial_rx_checker chk0 (
  .clk_in_clkbuf (clk_in_clkbuf),
  .reset_ibuf    (reset_ibuf),
  .i1            (i1),
  .i2            (i2),
  .bitslip_adj   (bitslip_adj),
  .data_out      (data_out),
  .data_valid    (data_valid),
  .dpa_loc       (dpa_loc),
  .dpa_err       (dpa_err)
);

`default_nettype wire

//--- serial_rx_top.sv
// Serial receive front end
// Link configuration, deserializer and word lock monitor on one clock

`timescale 1ns/100ps
`default_nettype none

module serial_rx_top
  import rx_pkg::*;
(
  input  logic  clk_in_clkbuf,
  input  logic  reset_ibuf,
  input  logic  i1,
  input  logic  i2,
  input  logic  bitslip_adj,
  output word_t data_out,
  output logic  data_valid,
  output logic  dpa_loc,
  output logic  dpa_err
);

  logic rx_enable;  // Deserializer runs while high
  logic slip_pulse; // One strobe per bitslip request

  // Enable and bitslip conditioning
  rx_link_config link_config0 (
    .clk_in_clkbuf (clk_in_clkbuf),
    .reset_ibuf    (reset_ibuf),
    .bitslip_adj   (bitslip_adj),
    .rx_enable     (rx_enable),
    .slip_pulse    (slip_pulse)
  );

  // Word output also feeds the lock monitor
  rx_deserializer deser0 (
    .clk_in_clkbuf (clk_in_clkbuf),
    .reset_ibuf    (reset_ibuf),
    .i1            (i1),
    .i2            (i2),
    .rx_enable     (rx_enable),
    .slip_pulse    (slip_pulse),
    .data_out      (data_out),
    .data_valid    (data_valid)
  );

  rx_lock_monitor lock_mon0 (
    .clk_in_clkbuf (clk_in_clkbuf),
    .reset_ibuf    (reset_ibuf),
    .data_out      (data_out),
    .data_valid    (data_valid),
    .slip_pulse    (slip_pulse),
    .dpa_loc       (dpa_loc),
    .dpa_err       (dpa_err)
  );

endmodule : serial_rx_top

`default_nettype wire

//--- rx_lock_monitor.sv
// Word alignment monitor
// Searches the received words for a run of training words, then reports
// lock, and raises a sticky error when the search runs too long

`timescale 1ns/100ps
`default_nettype none

module rx_lock_monitor
  import rx_pkg::*;
(
  input  logic  clk_in_clkbuf,
  input  logic  reset_ibuf,
  input  word_t data_out,
  input  logic  data_valid,
  input  logic  slip_pulse,
  output logic  dpa_loc,
  output logic  dpa_err
);

  lock_state_t state;
  lock_state_t state_next;
  match_cnt_t  match_cnt;      // Consecutive training words seen
  match_cnt_t  match_cnt_next;
  match_cnt_t  miss_cnt;       // Consecutive other words seen
  match_cnt_t  miss_cnt_next;
  logic        err_flag;
  logic        err_flag_next;
  logic        is_train;

  assign is_train = (data_out == train_word);

  always_comb begin
    state_next     = state;
    match_cnt_next = match_cnt;
    miss_cnt_next  = miss_cnt;
    err_flag_next  = err_flag;

    if (slip_pulse) begin
      // Boundary moved, alignment has to be found again
      state_next     = lock_search;
      match_cnt_next = '0;
      miss_cnt_next  = '0;
    end else if (data_valid) begin
      case (state)
        lock_search: begin
          if (is_train) begin
            miss_cnt_next = '0;
            if (match_cnt + match_cnt_t'(1) == lock_count) begin
              state_next     = lock_locked;
              match_cnt_next = '0;
              err_flag_next  = 1'b0; // Lock clears the error
            end else begin
              match_cnt_next = match_cnt + match_cnt_t'(1);
            end
          end else begin
            match_cnt_next = '0;
            if (miss_cnt + match_cnt_t'(1) >= search_limit) begin
              miss_cnt_next = search_limit; // Saturates at the limit
              err_flag_next = 1'b1;
            end else begin
              miss_cnt_next = miss_cnt + match_cnt_t'(1);
            end
          end
        end

        lock_locked: begin
          // Lock holds until a slip or a reset
          state_next = lock_locked;
        end

        default: begin
          state_next = lock_search;
        end
      endcase
    end
  end

  always_ff @(posedge clk_in_clkbuf or negedge reset_ibuf) begin
    if (!reset_ibuf) begin
      state     <= lock_search;
      match_cnt <= '0;
      miss_cnt  <= '0;
      err_flag  <= 1'b0;
    end else begin
      state     <= state_next;
      match_cnt <= match_cnt_next;
      miss_cnt  <= miss_cnt_next;
      err_flag  <= err_flag_next;
    end
  end

  // Output registers, one cycle behind the internal flags
  always_ff @(posedge clk_in_clkbuf or negedge reset_ibuf) begin
    if (!reset_ibuf) begin
      dpa_loc <= 1'b0;
      dpa_err <= 1'b0;
    end else begin
      dpa_loc <= (state == lock_locked);
      dpa_err <= err_flag;
    end
  end

endmodule : rx_lock_monitor

`default_nettype wire

//--- rx_deserializer.sv
// Serial to parallel converter
// Forms one serial bit per clock from i1 and i2, packs the bits into
// words MSB first and shifts the word boundary by one bit on a slip

`timescale 1ns/100ps
`default_nettype none

module rx_deserializer
  import rx_pkg::*;
(
  input  logic  clk_in_clkbuf,
  input  logic  reset_ibuf,
  input  logic  i1,
  input  logic  i2,
  input  logic  rx_enable,
  input  logic  slip_pulse,
  output word_t data_out,
  output logic  data_valid
);

  localparam bit_cnt_t last_bit = bit_cnt_t'(word_width - 1);

  logic     serial_bit;
  word_t    shift_reg;  // Bits collected so far, newest in the LSB
  word_t    next_word;  // Shift register contents after this cycle
  bit_cnt_t bit_cnt;    // Position of the current bit within the word
  logic     word_done;

  // Serial bit is the product of the two pins
  assign serial_bit = i1 & i2;

  // The current bit is part of the word that completes on this cycle
  assign next_word = {shift_reg[word_width-2:0], serial_bit};

  // A slip cycle holds the position, so the boundary moves by one bit
  assign word_done = rx_enable && !slip_pulse && (bit_cnt == last_bit);

  // Shift register samples every enabled cycle, slip cycles included
  always_ff @(posedge clk_in_clkbuf) begin
    if (rx_enable) begin
      shift_reg <= next_word;
    end
  end

  // Bit position
  always_ff @(posedge clk_in_clkbuf or negedge reset_ibuf) begin
    if (!reset_ibuf) begin
      bit_cnt <= '0;
    end else if (rx_enable && !slip_pulse) begin
      bit_cnt <= bit_cnt + bit_cnt_t'(1); // Wraps after the last bit
    end
  end

  // Word output register and its strobe
  always_ff @(posedge clk_in_clkbuf or negedge reset_ibuf) begin
    if (!reset_ibuf) begin
      data_out   <= '0;
      data_valid <= 1'b0;
    end else begin
      data_valid <= word_done; // One cycle per completed word
      if (word_done) begin
        data_out <= next_word; // Held until the next word replaces it
      end
    end
  end

endmodule : rx_deserializer

`default_nettype wire

//--- rx_link_config.sv
// Receiver link configuration
// Raises the receiver enable once reset is released and turns the
// bitslip_adj level into one slip pulse per rising edge

`timescale 1ns/100ps
`default_nettype none

module rx_link_config
  import rx_pkg::*;
(
  input  logic clk_in_clkbuf,
  input  logic reset_ibuf,
  input  logic bitslip_adj,
  output logic rx_enable,
  output logic slip_pulse
);

  logic bitslip_d; // Previous sample of bitslip_adj
  logic slip_edge;

  // Receiver enable, high from the first edge after reset release
  always_ff @(posedge clk_in_clkbuf or negedge reset_ibuf) begin
    if (!reset_ibuf) begin
      rx_enable <= 1'b0;
    end else begin
      rx_enable <= 1'b1;
    end
  end

  // A held request only counts once
  assign slip_edge = bitslip_adj & ~bitslip_d;

  always_ff @(posedge clk_in_clkbuf or negedge reset_ibuf) begin
    if (!reset_ibuf) begin
      bitslip_d  <= 1'b0;
      slip_pulse <= 1'b0;
    end else begin
      bitslip_d  <= bitslip_adj;
      slip_pulse <= slip_edge & rx_enable; // Slips only while receiving
    end
  end

endmodule : rx_link_config

`default_nettype wire

//--- rx_pkg.sv
// Shared definitions for the serial receive front end
// Word and counter widths, training word, lock limits and the lock FSM states

`default_nettype none

package rx_pkg;

  // Word geometry
  localparam int word_width = 4;

  typedef logic [word_width-1:0] word_t;    // One deserialized word
  typedef logic [1:0]            bit_cnt_t; // Bit position inside a word

  // Shared by the match and the miss counters
  typedef logic [4:0] match_cnt_t;

  // Training word used for word alignment
  // Its four rotations are all different, so only one boundary matches
  localparam word_t train_word = 4'b1100;

  // Consecutive training words needed before lock is declared
  localparam match_cnt_t lock_count = 5'd4;

  // Consecutive bad words in search before the error flag is raised
  localparam match_cnt_t search_limit = 5'd16;

  // Word alignment state
  typedef enum logic {
    lock_search, // Looking for a run of training words
    lock_locked  // Word boundary found
  } lock_state_t;

endpackage : rx_pkg

`default_nettype wire
